// File: hdl/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath and register file sizing
`define WORD_SIZE 16
`define REG_COUNT 4

// First fetch address after reset
`define RESET_PC 16'd0

// Instruction field positions
`define OPCODE_FIELD 15:12
`define RS_FIELD 11:10
`define RT_FIELD 9:8
`define RD_FIELD 7:6
`define FUNC_FIELD 5:0
`define IMM_FIELD 7:0
`define TARGET_FIELD 11:0

`endif

// File: hdl/cpuPkg.sv
package cpuPkg;

    // Primary opcode in bits 15 to 12
    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_ADI   = 4'd4,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_RTYPE = 4'd15
    } opcodeT;

    // Function field of R-type instructions
    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } funcT;

    // Operation selected in decode, performed in execute
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_PASSA,
        ALU_LHI
    } aluOpT;

endpackage

// File: hdl/stageIf.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

// Decode to execute, one instruction per cycle
interface issueIf import cpuPkg::*; ();
    logic valid;
    aluOpT aluOp;
    logic isBranch;
    logic branchOnEqual;
    logic useImm;
    logic memRead;
    logic memWrite;
    logic regWrite;
    logic isOutput;
    logic isHalt;
    logic [1:0] rs;
    logic [1:0] rt;
    logic [1:0] rd;
    logic [`WORD_SIZE-1:0] readData1;
    logic [`WORD_SIZE-1:0] readData2;
    logic [`WORD_SIZE-1:0] imm;
    logic [`WORD_SIZE-1:0] pc;

    modport driver (output valid, aluOp, isBranch, branchOnEqual, useImm, memRead,
        memWrite, regWrite, isOutput, isHalt, rs, rt, rd, readData1, readData2, imm, pc);
    modport receiver (input valid, aluOp, isBranch, branchOnEqual, useImm, memRead,
        memWrite, regWrite, isOutput, isHalt, rs, rt, rd, readData1, readData2, imm, pc);
endinterface

// EX/MEM latch contents seen by the result stage
interface retireIf;
    logic valid;
    logic regWrite;
    logic memToReg;
    logic isOutput;
    logic isHalt;
    logic [1:0] rd;
    logic [`WORD_SIZE-1:0] aluResult;

    modport driver (output valid, regWrite, memToReg, isOutput, isHalt, rd, aluResult);
    modport receiver (input valid, regWrite, memToReg, isOutput, isHalt, rd, aluResult);
endinterface

// File: hdl/regFile.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module regFile (
    input  logic                  Clk,
    input  logic                  reset,
    input  logic [1:0]            rs,
    input  logic [1:0]            rt,
    output logic [`WORD_SIZE-1:0] readData1,
    output logic [`WORD_SIZE-1:0] readData2,
    input  logic                  wbWrite,
    input  logic [1:0]            wbReg,
    input  logic [`WORD_SIZE-1:0] wbData
);
    logic [`WORD_SIZE-1:0] regs [`REG_COUNT];

    always_ff @(posedge Clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWrite) begin
            regs[wbReg] <= wbData;
        end
    end

    // Write-through so decode sees this cycle's writeback
    assign readData1 = (wbWrite && wbReg == rs) ? wbData : regs[rs];
    assign readData2 = (wbWrite && wbReg == rt) ? wbData : regs[rt];

endmodule

// File: hdl/decodeStage.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decodeStage import cpuPkg::*; (
    input  logic                  Clk,
    input  logic                  reset,
    output logic [`WORD_SIZE-1:0] instrAddr,
    output logic                  instrRead,
    input  logic [`WORD_SIZE-1:0] instrData,
    input  logic                  redirect,
    input  logic [`WORD_SIZE-1:0] redirectPc,
    input  logic [1:0]            exDestReg,
    input  logic                  exIsLoad,
    output logic [1:0]            rs,
    output logic [1:0]            rt,
    input  logic [`WORD_SIZE-1:0] readData1,
    input  logic [`WORD_SIZE-1:0] readData2,
    issueIf.driver                issue
);
    logic [`WORD_SIZE-1:0] pc;
    logic [`WORD_SIZE-1:0] nextPc;
    logic                  haltFetch;
    logic [`WORD_SIZE-1:0] ifidInstr;
    logic [`WORD_SIZE-1:0] ifidPc;
    logic                  ifidValid;
    opcodeT                opcode;
    funcT                  func;
    logic                  isRType;
    logic                  isJmp;
    logic                  isHlt;
    logic                  useRs;
    logic                  useRt;
    logic                  stall;
    logic                  issueOk;

    assign instrAddr = pc;
    assign instrRead = !haltFetch;

    assign opcode  = opcodeT'(ifidInstr[`OPCODE_FIELD]);
    assign func    = funcT'(ifidInstr[`FUNC_FIELD]);
    assign rs      = ifidInstr[`RS_FIELD];
    assign rt      = ifidInstr[`RT_FIELD];
    assign isRType = opcode == OP_RTYPE;
    assign isJmp   = ifidValid && opcode == OP_JMP;
    assign isHlt   = ifidValid && isRType && func == FN_HLT;

    // Source registers actually read, for the load-use check
    assign useRs = !(opcode == OP_JMP || opcode == OP_LHI || (isRType && func == FN_HLT));
    assign useRt = opcode == OP_BNE || opcode == OP_BEQ || opcode == OP_SWD ||
                   (isRType && func != FN_WWD && func != FN_HLT);
    assign stall = ifidValid && exIsLoad &&
                   ((useRs && rs == exDestReg) || (useRt && rt == exDestReg));
    assign issueOk = ifidValid && !stall && !redirect;

    always_comb begin
        if (redirect) begin
            nextPc = redirectPc;
        end else if (stall) begin
            nextPc = pc;
        end else if (isJmp) begin
            nextPc = {pc[`WORD_SIZE-1 -: 4], ifidInstr[`TARGET_FIELD]};
        end else begin
            nextPc = pc + 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            pc        <= `RESET_PC;
            ifidValid <= 1'b0;
            haltFetch <= 1'b0;
        end else begin
            if (!haltFetch) begin
                pc <= nextPc;
            end
            if (issueOk && isHlt) begin
                haltFetch <= 1'b1;
            end
            // Taken branch, JMP and halt all squash the fetched word
            if (redirect || haltFetch || (issueOk && (isJmp || isHlt))) begin
                ifidValid <= 1'b0;
            end else if (!stall) begin
                ifidValid <= 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (!stall) begin
            ifidInstr <= instrData;
            ifidPc    <= pc;
        end
    end

    always_comb begin
        issue.valid         = issueOk;
        issue.aluOp         = ALU_ADD;
        issue.isBranch      = 1'b0;
        issue.branchOnEqual = 1'b0;
        issue.useImm        = 1'b0;
        issue.memRead       = 1'b0;
        issue.memWrite      = 1'b0;
        issue.regWrite      = 1'b0;
        issue.isOutput      = 1'b0;
        issue.isHalt        = 1'b0;
        if (issueOk) begin
            case (opcode)
                OP_BNE, OP_BEQ: begin
                    issue.aluOp         = ALU_SUB;
                    issue.isBranch      = 1'b1;
                    issue.branchOnEqual = opcode == OP_BEQ;
                end
                OP_ADI: begin
                    issue.useImm   = 1'b1;
                    issue.regWrite = 1'b1;
                end
                OP_LHI: begin
                    issue.aluOp    = ALU_LHI;
                    issue.regWrite = 1'b1;
                end
                OP_LWD: begin
                    issue.useImm   = 1'b1;
                    issue.memRead  = 1'b1;
                    issue.regWrite = 1'b1;
                end
                OP_SWD: begin
                    issue.useImm   = 1'b1;
                    issue.memWrite = 1'b1;
                end
                OP_RTYPE: begin
                    case (func)
                        FN_ADD: issue.regWrite = 1'b1;
                        FN_SUB: begin
                            issue.aluOp    = ALU_SUB;
                            issue.regWrite = 1'b1;
                        end
                        FN_AND: begin
                            issue.aluOp    = ALU_AND;
                            issue.regWrite = 1'b1;
                        end
                        FN_ORR: begin
                            issue.aluOp    = ALU_OR;
                            issue.regWrite = 1'b1;
                        end
                        FN_WWD: begin
                            issue.aluOp    = ALU_PASSA;
                            issue.isOutput = 1'b1;
                        end
                        FN_HLT: issue.isHalt = 1'b1;
                        default: ;
                    endcase
                end
                // JMP travels on as a plain retiring bubble
                default: ;
            endcase
        end
    end

    assign issue.rs        = rs;
    assign issue.rt        = rt;
    assign issue.rd        = isRType ? ifidInstr[`RD_FIELD] : rt;
    assign issue.readData1 = readData1;
    assign issue.readData2 = readData2;
    assign issue.imm       = `WORD_SIZE'($signed(ifidInstr[`IMM_FIELD]));
    assign issue.pc        = ifidPc;

endmodule

// File: hdl/executeStage.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module executeStage import cpuPkg::*; (
    input  logic                  Clk,
    input  logic                  reset,
    issueIf.receiver              issue,
    output logic                  redirect,
    output logic [`WORD_SIZE-1:0] redirectPc,
    output logic [1:0]            exDestReg,
    output logic                  exIsLoad,
    input  logic                  wbWrite,
    input  logic [1:0]            wbReg,
    input  logic [`WORD_SIZE-1:0] wbData,
    output logic [`WORD_SIZE-1:0] dataAddr,
    output logic                  dataRead,
    output logic                  dataWrite,
    output logic [`WORD_SIZE-1:0] dataWdata,
    retireIf.driver               retire
);
    logic                  exValid;
    aluOpT                 exAluOp;
    logic                  exIsBranch;
    logic                  exBranchOnEqual;
    logic                  exUseImm;
    logic                  exMemRead;
    logic                  exMemWrite;
    logic                  exRegWrite;
    logic                  exIsOutput;
    logic                  exIsHalt;
    logic [1:0]            exRs;
    logic [1:0]            exRt;
    logic [1:0]            exRd;
    logic [`WORD_SIZE-1:0] exRead1;
    logic [`WORD_SIZE-1:0] exRead2;
    logic [`WORD_SIZE-1:0] exImm;
    logic [`WORD_SIZE-1:0] exPc;
    logic [`WORD_SIZE-1:0] opA;
    logic [`WORD_SIZE-1:0] fwdB;
    logic [`WORD_SIZE-1:0] opB;
    logic [`WORD_SIZE-1:0] aluOut;
    logic                  fwdFromMem;

    // ID/EX latch
    always_ff @(posedge Clk) begin
        if (reset) begin
            exValid    <= 1'b0;
            exAluOp    <= ALU_ADD;
            exIsBranch <= 1'b0;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
            exRegWrite <= 1'b0;
            exIsOutput <= 1'b0;
            exIsHalt   <= 1'b0;
        end else begin
            exValid    <= issue.valid;
            exAluOp    <= issue.aluOp;
            exIsBranch <= issue.isBranch;
            exMemRead  <= issue.memRead;
            exMemWrite <= issue.memWrite;
            exRegWrite <= issue.regWrite;
            exIsOutput <= issue.isOutput;
            exIsHalt   <= issue.isHalt;
        end
        exBranchOnEqual <= issue.branchOnEqual;
        exUseImm        <= issue.useImm;
        exRs            <= issue.rs;
        exRt            <= issue.rt;
        exRd            <= issue.rd;
        exRead1         <= issue.readData1;
        exRead2         <= issue.readData2;
        exImm           <= issue.imm;
        exPc            <= issue.pc;
    end

    // A load in EX/MEM has no data yet, the stall covers that case
    assign fwdFromMem = retire.regWrite && !retire.memToReg;

    always_comb begin
        if (fwdFromMem && retire.rd == exRs) begin
            opA = retire.aluResult;
        end else if (wbWrite && wbReg == exRs) begin
            opA = wbData;
        end else begin
            opA = exRead1;
        end
        if (fwdFromMem && retire.rd == exRt) begin
            fwdB = retire.aluResult;
        end else if (wbWrite && wbReg == exRt) begin
            fwdB = wbData;
        end else begin
            fwdB = exRead2;
        end
    end

    assign opB = exUseImm ? exImm : fwdB;

    always_comb begin
        case (exAluOp)
            ALU_SUB: aluOut = opA - opB;
            ALU_AND: aluOut = opA & opB;
            ALU_OR:  aluOut = opA | opB;
            ALU_PASSA: aluOut = opA;
            ALU_LHI: aluOut = {exImm[`IMM_FIELD], 8'h00};
            default: aluOut = opA + opB;
        endcase
    end

    // Branch compares through the subtractor
    assign redirect   = exValid && exIsBranch && ((aluOut == '0) == exBranchOnEqual);
    assign redirectPc = exPc + 1'b1 + exImm;
    assign exDestReg  = exRd;
    assign exIsLoad   = exMemRead;

    // EX/MEM latch
    always_ff @(posedge Clk) begin
        if (reset) begin
            retire.valid    <= 1'b0;
            retire.regWrite <= 1'b0;
            retire.memToReg <= 1'b0;
            retire.isOutput <= 1'b0;
            retire.isHalt   <= 1'b0;
            dataRead        <= 1'b0;
            dataWrite       <= 1'b0;
        end else begin
            retire.valid    <= exValid;
            retire.regWrite <= exRegWrite;
            retire.memToReg <= exMemRead;
            retire.isOutput <= exIsOutput;
            retire.isHalt   <= exIsHalt;
            dataRead        <= exMemRead;
            dataWrite       <= exMemWrite;
        end
        retire.rd        <= exRd;
        retire.aluResult <= aluOut;
        dataWdata        <= fwdB;
    end

    assign dataAddr = retire.aluResult;

endmodule

// File: hdl/resultStage.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module resultStage (
    input  logic                  Clk,
    input  logic                  reset,
    retireIf.receiver             retire,
    input  logic [`WORD_SIZE-1:0] dataRdata,
    output logic                  wbWrite,
    output logic [1:0]            wbReg,
    output logic [`WORD_SIZE-1:0] wbData,
    output logic [`WORD_SIZE-1:0] numInst,
    output logic [`WORD_SIZE-1:0] outputPort,
    output logic                  halted
);
    logic                  mwValid;
    logic                  mwMemToReg;
    logic                  mwIsOutput;
    logic                  mwIsHalt;
    logic [`WORD_SIZE-1:0] mwAlu;
    logic [`WORD_SIZE-1:0] mwLoad;

    // MEM/WB latch, load data captured with the instruction
    always_ff @(posedge Clk) begin
        if (reset) begin
            mwValid    <= 1'b0;
            wbWrite    <= 1'b0;
            mwIsOutput <= 1'b0;
            mwIsHalt   <= 1'b0;
        end else begin
            mwValid    <= retire.valid;
            wbWrite    <= retire.regWrite;
            mwIsOutput <= retire.isOutput;
            mwIsHalt   <= retire.isHalt;
        end
        mwMemToReg <= retire.memToReg;
        wbReg      <= retire.rd;
        mwAlu      <= retire.aluResult;
        mwLoad     <= dataRdata;
    end

    assign wbData = mwMemToReg ? mwLoad : mwAlu;

    // Retirement
    always_ff @(posedge Clk) begin
        if (reset) begin
            numInst    <= '0;
            outputPort <= '0;
            halted     <= 1'b0;
        end else if (mwValid) begin
            numInst <= numInst + 1'b1;
            if (mwIsOutput) begin
                outputPort <= wbData;
            end
            if (mwIsHalt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

// File: hdl/pipelineCore.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module pipelineCore (
    input  logic                  Clk,
    input  logic                  reset,
    output logic [`WORD_SIZE-1:0] instrAddr,
    output logic                  instrRead,
    input  logic [`WORD_SIZE-1:0] instrData,
    output logic [`WORD_SIZE-1:0] dataAddr,
    output logic                  dataRead,
    output logic                  dataWrite,
    output logic [`WORD_SIZE-1:0] dataWdata,
    input  logic [`WORD_SIZE-1:0] dataRdata,
    output logic [`WORD_SIZE-1:0] numInst,
    output logic [`WORD_SIZE-1:0] outputPort,
    output logic                  halted
);
    logic [1:0]            rs;
    logic [1:0]            rt;
    logic [`WORD_SIZE-1:0] readData1;
    logic [`WORD_SIZE-1:0] readData2;
    logic                  redirect;
    logic [`WORD_SIZE-1:0] redirectPc;
    logic [1:0]            exDestReg;
    logic                  exIsLoad;
    logic                  wbWrite;
    logic [1:0]            wbReg;
    logic [`WORD_SIZE-1:0] wbData;

    issueIf  issueBus ();
    retireIf retireBus ();

    regFile regFileInst (
        .Clk, .reset, .rs, .rt, .readData1, .readData2, .wbWrite, .wbReg, .wbData
    );

    decodeStage decodeInst (
        .Clk, .reset, .instrAddr, .instrRead, .instrData, .redirect, .redirectPc,
        .exDestReg, .exIsLoad, .rs, .rt, .readData1, .readData2, .issue(issueBus)
    );

    executeStage executeInst (
        .Clk, .reset, .issue(issueBus), .redirect, .redirectPc, .exDestReg, .exIsLoad,
        .wbWrite, .wbReg, .wbData, .dataAddr, .dataRead, .dataWrite, .dataWdata,
        .retire(retireBus)
    );

    resultStage resultInst (
        .Clk, .reset, .retire(retireBus), .dataRdata, .wbWrite, .wbReg, .wbData,
        .numInst, .outputPort, .halted
    );

endmodule

// File: testbench/pipelineCore_sva.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module pipelineCore_sva (
    input logic                  Clk,
    input logic                  reset,
    input logic                  instrRead,
    input logic                  dataRead,
    input logic                  dataWrite,
    input logic [`WORD_SIZE-1:0] numInst,
    input logic [`WORD_SIZE-1:0] outputPort,
    input logic                  halted
);
    // Synchronous reset clears memory strobes and status
    resetState: assert property (@(posedge Clk) reset |=>
        !dataRead && !dataWrite && !halted && numInst == '0 && outputPort == '0)
        else $error("Core state not cleared by reset");

    memExclusive: assert property (@(posedge Clk) disable iff (reset)
        !(dataRead && dataWrite))
        else $error("Data memory read and write strobes high together");

    retireStep: assert property (@(posedge Clk) disable iff (reset)
        numInst == $past(numInst) || numInst == $past(numInst) + 16'd1)
        else $error("Retire counter jumped by more than one");

    outputOnRetire: assert property (@(posedge Clk) disable iff (reset)
        $changed(outputPort) |-> $changed(numInst))
        else $error("Output port changed without a retirement");

    // Once halted the core is frozen until reset
    haltFrozen: assert property (@(posedge Clk) disable iff (reset)
        halted |=> halted && !instrRead && $stable(numInst) && $stable(outputPort))
        else $error("Core activity after halt");

endmodule

// File: testbench/pipelineCore_tb.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module pipelineCore_tb import cpuPkg::*; ();
    localparam int PROG_LEN = 37;
    localparam int EXEC_COUNT = 33;
    localparam int CYCLE_LIMIT = 4 * PROG_LEN + 40;

    logic                  Clk;
    logic                  reset;
    logic [`WORD_SIZE-1:0] instrAddr;
    logic                  instrRead;
    logic [`WORD_SIZE-1:0] instrData;
    logic [`WORD_SIZE-1:0] dataAddr;
    logic                  dataRead;
    logic                  dataWrite;
    logic [`WORD_SIZE-1:0] dataWdata;
    logic [`WORD_SIZE-1:0] dataRdata;
    logic [`WORD_SIZE-1:0] numInst;
    logic [`WORD_SIZE-1:0] outputPort;
    logic                  halted;

    logic [`WORD_SIZE-1:0] prog [PROG_LEN];
    logic [`WORD_SIZE-1:0] dmem [64];
    logic [`WORD_SIZE-1:0] expected [$];
    logic [`WORD_SIZE-1:0] lastOut;
    logic [`WORD_SIZE-1:0] wantOut;
    logic [31:0]           rngState;
    int                    errors;
    int                    cycles;

    pipelineCore pipelineCore_inst (.*);

    bind pipelineCore pipelineCore_sva svaInst (.*);

    always #20 Clk = ~Clk;

    always @(posedge Clk) begin
        cycles <= cycles + 1;
    end

    // Fetch past the program end sees HLT
    assign instrData = (instrAddr < PROG_LEN) ? prog[instrAddr] :
                       {OP_RTYPE, 6'd0, FN_HLT};
    assign dataRdata = dmem[dataAddr[5:0]];

    always @(posedge Clk) begin
        if (dataWrite) begin
            dmem[dataAddr[5:0]] <= dataWdata;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [15:0] encodeR(input logic [1:0] rs, input logic [1:0] rt,
                                            input logic [1:0] rd, input funcT fn);
        return {OP_RTYPE, rs, rt, rd, fn};
    endfunction

    function automatic logic [15:0] encodeI(input opcodeT op, input logic [1:0] rs,
                                            input logic [1:0] rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic loadProgram();
        // ALU chain with forwarding
        prog[0]  = encodeI(OP_ADI, 2'd0, 2'd1, 8'd5);
        prog[1]  = encodeR(2'd1, 2'd0, 2'd0, FN_WWD);
        prog[2]  = encodeI(OP_ADI, 2'd1, 2'd2, 8'hFD);
        prog[3]  = encodeR(2'd2, 2'd0, 2'd0, FN_WWD);
        prog[4]  = encodeI(OP_LHI, 2'd0, 2'd3, 8'h12);
        prog[5]  = encodeR(2'd3, 2'd0, 2'd0, FN_WWD);
        prog[6]  = encodeR(2'd3, 2'd1, 2'd3, FN_ADD);
        prog[7]  = encodeR(2'd3, 2'd0, 2'd0, FN_WWD);
        prog[8]  = encodeR(2'd3, 2'd2, 2'd0, FN_SUB);
        prog[9]  = encodeR(2'd0, 2'd0, 2'd0, FN_WWD);
        prog[10] = encodeR(2'd0, 2'd3, 2'd1, FN_AND);
        prog[11] = encodeR(2'd1, 2'd0, 2'd0, FN_WWD);
        prog[12] = encodeR(2'd1, 2'd2, 2'd2, FN_ORR);
        prog[13] = encodeR(2'd2, 2'd0, 2'd0, FN_WWD);
        // Store, load and load-use
        prog[14] = encodeI(OP_LHI, 2'd0, 2'd0, 8'd0);
        prog[15] = encodeI(OP_SWD, 2'd0, 2'd2, 8'd10);
        prog[16] = encodeI(OP_LWD, 2'd0, 2'd1, 8'd10);
        prog[17] = encodeR(2'd1, 2'd3, 2'd1, FN_ADD);
        prog[18] = encodeR(2'd1, 2'd0, 2'd0, FN_WWD);
        prog[19] = encodeI(OP_LWD, 2'd0, 2'd2, 8'd20);
        prog[20] = encodeR(2'd2, 2'd0, 2'd0, FN_WWD);
        prog[21] = encodeI(OP_LWD, 2'd0, 2'd3, 8'd33);
        prog[22] = encodeR(2'd3, 2'd2, 2'd3, FN_ADD);
        prog[23] = encodeR(2'd3, 2'd0, 2'd0, FN_WWD);
        // Control transfers
        // The r0 marker sits only in the shadow of taken transfers
        prog[24] = encodeI(OP_ADI, 2'd0, 2'd0, 8'h55);
        prog[25] = encodeI(OP_BEQ, 2'd1, 2'd1, 8'd2);
        prog[26] = encodeR(2'd0, 2'd0, 2'd0, FN_WWD);
        prog[27] = encodeR(2'd0, 2'd0, 2'd0, FN_WWD);
        prog[28] = encodeI(OP_BNE, 2'd1, 2'd1, 8'd2);
        prog[29] = encodeR(2'd2, 2'd0, 2'd0, FN_WWD);
        prog[30] = encodeI(OP_BNE, 2'd1, 2'd0, 8'd1);
        prog[31] = encodeR(2'd0, 2'd0, 2'd0, FN_WWD);
        prog[32] = encodeI(OP_BEQ, 2'd1, 2'd0, 8'd1);
        prog[33] = encodeR(2'd1, 2'd0, 2'd0, FN_WWD);
        prog[34] = {OP_JMP, 12'd36};
        prog[35] = encodeR(2'd0, 2'd0, 2'd0, FN_WWD);
        prog[36] = encodeR(2'd0, 2'd0, 2'd0, FN_HLT);
    endtask

    // Expected outputPort values in program order
    task automatic buildExpected();
        expected.push_back(16'h0005);
        expected.push_back(16'h0002);
        expected.push_back(16'h1200);
        expected.push_back(16'h1205);
        expected.push_back(16'h1203);
        expected.push_back(16'h1201);
        expected.push_back(16'h1203);
        expected.push_back(16'h1203 + 16'h1205);
        expected.push_back(dmem[20]);
        expected.push_back(dmem[33] + dmem[20]);
        expected.push_back(dmem[20]);
        expected.push_back(16'h2408);
    endtask

    always @(negedge Clk) begin
        if (!reset && outputPort !== lastOut) begin
            if (expected.size() == 0) begin
                errors++;
                $display("Output port written more times than the program allows at %0t",
                         $time);
            end else begin
                wantOut = expected.pop_front();
                assert (outputPort == wantOut) else begin
                    errors++;
                    $display("ERROR %0t: outputPort is %h, expected %h",
                             $time, outputPort, wantOut);
                end
            end
            lastOut = outputPort;
        end
    end

    initial begin
        Clk = 1'b0;
        reset = 1'b1;
        errors = 0;
        cycles = 0;
        lastOut = '0;
        rngState = 32'd76731;
        for (int i = 0; i < 64; i++) begin
            rngState = xorshift(rngState);
            dmem[i] = rngState[15:0];
        end
        loadProgram();
        buildExpected();
        repeat (2) @(posedge Clk);
        #1 reset = 1'b0;
        while (!halted && cycles < CYCLE_LIMIT) begin
            @(posedge Clk);
        end
        if (!halted) begin
            errors++;
            $display("Program never halted within %0d cycles", CYCLE_LIMIT);
        end else begin
            repeat (5) @(posedge Clk);
            assert (numInst == EXEC_COUNT) else begin
                errors++;
                $display("ERROR %0t: numInst is %0d, expected %0d",
                         $time, numInst, EXEC_COUNT);
            end
            if (expected.size() != 0) begin
                errors++;
                $display("%0d expected outputs never appeared", expected.size());
            end
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+hdl
hdl/cpuPkg.sv
hdl/stageIf.sv
hdl/regFile.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/resultStage.sv
hdl/pipelineCore.sv
testbench/pipelineCore_sva.sv
testbench/pipelineCore_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -f tb.f --top-module pipelineCore_tb \
    && ./obj_dir/VpipelineCore_tb | grep "TESTBENCH PASSED" \
    || { echo "Simulation did not pass"; exit 1; }
